/* logic/logger_pkg.sv */
`default_nettype none

package logger_pkg;

    // ----------------------------------------
    // Network and tile configuration
    // ----------------------------------------
    localparam int noc_data_w = 64;
    localparam int xy_w       = 4;

    localparam logic [xy_w-1:0] tile_x   = 4'd2;
    localparam logic [xy_w-1:0] tile_y   = 4'd1;
    localparam logic [xy_w-1:0] udp_tx_x = 4'd0;
    localparam logic [xy_w-1:0] udp_tx_y = 4'd3;

    localparam logic [7:0] msg_udp_tx_segment = 8'h12;

    // ----------------------------------------
    // Log memory geometry
    // ----------------------------------------
    localparam int log_addr_w        = 6;
    localparam int log_depth         = 1 << log_addr_w;
    localparam int log_client_addr_w = 16;
    localparam int log_ts_w          = 16;
    localparam int log_event_w       = 16;
    localparam int log_entry_w       = log_ts_w + log_event_w;
    localparam int log_rd_req_w      = log_addr_w + 1;
    localparam int log_rd_resp_w     = log_client_addr_w + log_entry_w;
    localparam int log_rd_resp_bytes = 8;

    // ----------------------------------------
    // Flit layouts
    // ----------------------------------------
    typedef struct packed {
        logic [xy_w-1:0]                 dst_x;
        logic [xy_w-1:0]                 dst_y;
        logic [xy_w-1:0]                 src_x;
        logic [xy_w-1:0]                 src_y;
        logic [7:0]                      msg_len;         // Flits after the header
        logic [7:0]                      msg_type;
        logic [7:0]                      metadata_flits;
        logic [noc_data_w-4*xy_w-25:0]   pad;
    } noc_hdr_flit;

    typedef struct packed {
        logic [15:0] src_ip;
        logic [15:0] dst_ip;
        logic [7:0]  src_port;
        logic [7:0]  dst_port;
        logic [15:0] data_length;
    } udp_meta_flit;

    typedef struct packed {
        logic [log_ts_w-1:0]    timestamp;
        logic [log_event_w-1:0] event_code;
    } log_entry;

    // Top address bit asks for the recorder address instead of memory
    typedef struct packed {
        logic [log_addr_w:0] req_addr;
    } log_rd_req;

    typedef struct packed {
        logic [noc_data_w-log_rd_req_w-1:0] pad;
        log_rd_req                          rd_req;
    } log_rd_req_flit;

    typedef struct packed {
        logic [log_client_addr_w-1:0] resp_addr;
        logic [log_entry_w-1:0]       resp_data;
    } log_rd_resp;

    typedef struct packed {
        logic [noc_data_w-log_rd_resp_w-1:0] pad;
        log_rd_resp                          rd_resp;
    } log_rd_resp_flit;

    // ----------------------------------------
    // Datapath mux selects
    // ----------------------------------------
    typedef enum logic [1:0] {
        sel_hdr,
        sel_meta,
        sel_resp
    } out_sel;

    typedef enum logic {
        sel_mem,
        sel_curr_addr
    } data_sel;

endpackage

`default_nettype wire

/* logic/log_recorder.sv */
`timescale 1ns/10ps
`default_nettype none

module log_recorder
    import logger_pkg::*;
(
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   rec_val
    ,input  logic [log_event_w-1:0] rec_event

    ,output logic                   mem_wr_en
    ,output logic [log_addr_w-1:0]  mem_wr_addr
    ,output log_entry               mem_wr_entry

    ,output logic [log_addr_w:0]    curr_addr
);

    logic [log_ts_w-1:0] timestamp;
    logic                log_full;

    assign log_full = curr_addr[log_addr_w];     // Only 64 sets the top bit

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;       // Free running and wraps
        end
    end

    // Write pointer stops at full so later events are dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            curr_addr <= '0;
        end else if (mem_wr_en) begin
            curr_addr <= curr_addr + 1'b1;
        end
    end

    assign mem_wr_en   = rec_val && !log_full;
    assign mem_wr_addr = curr_addr[log_addr_w-1:0];

    always_comb begin
        mem_wr_entry            = '0;
        mem_wr_entry.timestamp  = timestamp;
        mem_wr_entry.event_code = rec_event;
    end

    a_addr_saturates: assert property (
        @(posedge clk) disable iff (!arst_n)
        curr_addr <= log_depth
    ) else $error("log_recorder write address ran past the end of the log");

endmodule

`default_nettype wire

/* logic/log_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module log_mem
    import logger_pkg::*;
(
     input  logic                  clk

    ,input  logic                  wr_en
    ,input  logic [log_addr_w-1:0] wr_addr
    ,input  log_entry              wr_entry

    ,input  logic                  rd_en
    ,input  logic [log_addr_w-1:0] rd_addr
    ,output log_entry              rd_entry
);

    log_entry mem [log_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // Read data holds until the next enabled read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_entry <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* logic/log_read_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module log_read_ctrl
    import logger_pkg::*;
(
     input  logic                clk
    ,input  logic                arst_n

    ,input  logic                noc_in_val
    ,input  logic                read_metadata

    ,output logic                store_meta
    ,output logic                store_req
    ,output logic                store_resp
    ,output logic                mem_rd_en
    ,output logger_pkg::out_sel  out_sel
    ,output logger_pkg::data_sel data_sel
    ,output logic                noc_out_val
);

    typedef enum logic [2:0] {
        idle,
        meta,
        req,
        mem_rd,
        mem_wait,
        send_hdr,
        send_meta,
        send_resp
    } state_e;

    state_e state;
    state_e state_next;
    logic   meta_rd_q;

    // ----------------------------------------
    // State and branch registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= idle;
            meta_rd_q <= 1'b0;
        end else begin
            state <= state_next;
            if (store_req) begin
                meta_rd_q <= read_metadata;      // Kept for the response flit
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle:      if (noc_in_val) state_next = meta;   // Header flit is not inspected
            meta:      if (noc_in_val) state_next = req;
            req: begin
                if (noc_in_val) begin
                    state_next = read_metadata ? send_hdr : mem_rd;
                end
            end
            mem_rd:    state_next = mem_wait;
            mem_wait:  state_next = send_hdr;
            send_hdr:  state_next = send_meta;
            send_meta: state_next = send_resp;
            send_resp: state_next = idle;
            default:   state_next = idle;
        endcase
    end

    // ----------------------------------------
    // Output decode
    // ----------------------------------------
    always_comb begin
        store_meta  = (state == meta) && noc_in_val;
        store_req   = (state == req) && noc_in_val;
        mem_rd_en   = (state == mem_rd);
        store_resp  = (state == mem_wait);      // Memory data is valid this cycle
        noc_out_val = (state == send_hdr) || (state == send_meta) || (state == send_resp);
        out_sel     = sel_hdr;
        data_sel    = sel_mem;
        case (state)
            send_meta: out_sel = sel_meta;
            send_resp: begin
                out_sel  = sel_resp;
                data_sel = meta_rd_q ? sel_curr_addr : sel_mem;
            end
            default: ;
        endcase
    end

    // The sender waits for the whole reply before starting a new request
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state inside {mem_rd, mem_wait, send_hdr, send_meta, send_resp}) |-> !noc_in_val
    ) else $error("log_read_ctrl got a flit while a reply was pending");

endmodule

`default_nettype wire

/* logic/log_read_datap.sv */
`timescale 1ns/10ps
`default_nettype none

module log_read_datap
    import logger_pkg::*;
(
     input  logic                  clk

    ,input  logic [noc_data_w-1:0] noc_in_data
    ,input  log_entry              mem_rd_entry

    ,input  logic                  store_meta
    ,input  logic                  store_req
    ,input  logic                  store_resp
    ,input  logger_pkg::out_sel    out_sel
    ,input  logger_pkg::data_sel   data_sel

    ,input  logic [log_addr_w:0]   curr_addr

    ,output logic [log_addr_w-1:0] mem_rd_addr
    ,output logic                  read_metadata
    ,output logic [noc_data_w-1:0] noc_out_data
);

    udp_meta_flit    meta_q;
    log_rd_req       req_q;
    log_entry        entry_q;
    udp_meta_flit    meta_in;
    log_rd_req_flit  req_in;

    noc_hdr_flit     resp_hdr;
    udp_meta_flit    resp_meta;
    log_rd_resp_flit resp_flit;

    logic [log_client_addr_w-1:0] padded_curr_addr;

    assign meta_in = noc_in_data;
    assign req_in  = noc_in_data;

    // ----------------------------------------
    // Request and entry registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (store_meta) begin
            meta_q <= meta_in;
        end
        if (store_req) begin
            req_q <= req_in.rd_req;
        end
        if (store_resp) begin
            entry_q <= mem_rd_entry;
        end
    end

    assign read_metadata = req_in.rd_req.req_addr[log_addr_w];  // Seen while the flit arrives
    assign mem_rd_addr   = req_q.req_addr[log_addr_w-1:0];

    assign padded_curr_addr = {{(log_client_addr_w-log_addr_w-1){1'b0}}, curr_addr};

    // ----------------------------------------
    // Reply flits
    // ----------------------------------------
    always_comb begin
        resp_hdr                = '0;
        resp_hdr.dst_x          = udp_tx_x;
        resp_hdr.dst_y          = udp_tx_y;
        resp_hdr.src_x          = tile_x;
        resp_hdr.src_y          = tile_y;
        resp_hdr.msg_len        = 8'd2;          // One metadata and one response flit
        resp_hdr.msg_type       = msg_udp_tx_segment;
        resp_hdr.metadata_flits = 8'd1;
    end

    always_comb begin
        resp_meta             = '0;
        resp_meta.src_ip      = meta_q.dst_ip;   // Reply goes back to the requester
        resp_meta.dst_ip      = meta_q.src_ip;
        resp_meta.src_port    = meta_q.dst_port;
        resp_meta.dst_port    = meta_q.src_port;
        resp_meta.data_length = log_rd_resp_bytes[15:0];
    end

    always_comb begin
        resp_flit                   = '0;
        resp_flit.rd_resp.resp_addr = {{(log_client_addr_w-log_rd_req_w){1'b0}}, req_q.req_addr};
        if (data_sel == sel_mem) begin
            resp_flit.rd_resp.resp_data = entry_q;
        end else begin
            resp_flit.rd_resp.resp_data[log_entry_w-1 -: log_client_addr_w] = padded_curr_addr;
        end
    end

    always_comb begin
        case (out_sel)
            sel_hdr:  noc_out_data = resp_hdr;
            sel_meta: noc_out_data = resp_meta;
            default:  noc_out_data = resp_flit;
        endcase
    end

endmodule

`default_nettype wire

/* logic/logger_tile.sv */
`timescale 1ns/10ps
`default_nettype none

module logger_tile
    import logger_pkg::*;
(
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   rec_val
    ,input  logic [log_event_w-1:0] rec_event

    ,input  logic                   noc_in_val
    ,input  logic [noc_data_w-1:0]  noc_in_data

    ,output logic                   noc_out_val
    ,output logic [noc_data_w-1:0]  noc_out_data
);

    logic                  mem_wr_en;
    logic [log_addr_w-1:0] mem_wr_addr;
    log_entry              mem_wr_entry;
    logic [log_addr_w:0]   curr_addr;

    logic                  mem_rd_en;
    logic [log_addr_w-1:0] mem_rd_addr;
    log_entry              mem_rd_entry;

    logic                  store_meta;
    logic                  store_req;
    logic                  store_resp;
    logic                  read_metadata;
    logger_pkg::out_sel    out_sel;
    logger_pkg::data_sel   data_sel;

    log_recorder u_recorder (
         .clk          (clk)
        ,.arst_n       (arst_n)
        ,.rec_val      (rec_val)
        ,.rec_event    (rec_event)
        ,.mem_wr_en    (mem_wr_en)
        ,.mem_wr_addr  (mem_wr_addr)
        ,.mem_wr_entry (mem_wr_entry)
        ,.curr_addr    (curr_addr)
    );

    log_mem u_mem (
         .clk      (clk)
        ,.wr_en    (mem_wr_en)
        ,.wr_addr  (mem_wr_addr)
        ,.wr_entry (mem_wr_entry)
        ,.rd_en    (mem_rd_en)
        ,.rd_addr  (mem_rd_addr)
        ,.rd_entry (mem_rd_entry)
    );

    log_read_ctrl u_ctrl (
         .clk           (clk)
        ,.arst_n        (arst_n)
        ,.noc_in_val    (noc_in_val)
        ,.read_metadata (read_metadata)
        ,.store_meta    (store_meta)
        ,.store_req     (store_req)
        ,.store_resp    (store_resp)
        ,.mem_rd_en     (mem_rd_en)
        ,.out_sel       (out_sel)
        ,.data_sel      (data_sel)
        ,.noc_out_val   (noc_out_val)
    );

    log_read_datap u_datap (
         .clk           (clk)
        ,.noc_in_data   (noc_in_data)
        ,.mem_rd_entry  (mem_rd_entry)
        ,.store_meta    (store_meta)
        ,.store_req     (store_req)
        ,.store_resp    (store_resp)
        ,.out_sel       (out_sel)
        ,.data_sel      (data_sel)
        ,.curr_addr     (curr_addr)
        ,.mem_rd_addr   (mem_rd_addr)
        ,.read_metadata (read_metadata)
        ,.noc_out_data  (noc_out_data)
    );

endmodule

`default_nettype wire

/* sim/logger_tile_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module logger_tile_tb
    import logger_pkg::*;
();

    localparam int num_events     = 40;
    localparam int num_fill       = 30;                 // Six more than the free space
    localparam int num_meta_reads = 8;
    localparam int num_tests      = 2 * num_events + num_fill + (log_depth - num_events)
                                    + num_meta_reads + 1;
    localparam int timeout_cycles = num_tests * 12 + 400;

    logic                   clk;
    logic                   arst_n;
    logic                   rec_val;
    logic [log_event_w-1:0] rec_event;
    logic                   noc_in_val;
    logic [noc_data_w-1:0]  noc_in_data;
    logic                   noc_out_val;
    logic [noc_data_w-1:0]  noc_out_data;

    log_entry            model_mem [log_depth];
    int                  model_count;
    logic [log_ts_w-1:0] model_ts;
    logic [31:0]         lcg_state;
    int                  cycle_count = 0;
    int                  i;
    logic                keep;

    logger_tile dut0 (
         .clk          (clk)
        ,.arst_n       (arst_n)
        ,.rec_val      (rec_val)
        ,.rec_event    (rec_event)
        ,.noc_in_val   (noc_in_val)
        ,.noc_in_data  (noc_in_data)
        ,.noc_out_val  (noc_out_val)
        ,.noc_out_data (noc_out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycles since reset give the timestamp an event gets
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_ts <= '0;
        end else begin
            model_ts <= model_ts + 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_run("the run took too many cycles and was stopped");
        end
    end

    // ----------------------------------------
    // Random numbers and failure handling
    // ----------------------------------------
    function automatic logic [15:0] rand_half();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_half()) % n;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_hdr(input string name, input noc_hdr_flit exp, input noc_hdr_flit act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_meta(input string name, input udp_meta_flit exp,
                              input udp_meta_flit act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input log_rd_resp_flit exp,
                              input log_rd_resp_flit act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_val(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic record_event(input logic [log_event_w-1:0] ev, input logic hold);
        @(posedge clk);
        #1;
        rec_val   = 1'b1;
        rec_event = ev;
        if (model_count < log_depth) begin
            model_mem[model_count] = {model_ts, ev};   // Written at the next edge
            model_count++;
        end
        if (!hold) begin
            @(posedge clk);
            #1;
            rec_val = 1'b0;
        end
    endtask

    task automatic read_log(input string name, input logic [log_addr_w:0] addr);
        udp_meta_flit    req_meta;
        udp_meta_flit    exp_meta;
        noc_hdr_flit     exp_hdr;
        log_rd_req_flit  req_flit;
        log_rd_resp_flit exp_resp;
        int              wait_n;
        int              exp_wait;

        req_meta.src_ip      = rand_half();
        req_meta.dst_ip      = rand_half();
        req_meta.src_port    = 8'(rand_half());
        req_meta.dst_port    = 8'(rand_half());
        req_meta.data_length = rand_half();
        req_flit             = '0;
        req_flit.rd_req.req_addr = addr;

        @(posedge clk);
        #1;
        noc_in_val  = 1'b1;
        noc_in_data = {rand_half(), rand_half(), rand_half(), rand_half()};  // Ignored header
        @(posedge clk);
        #1;
        noc_in_data = req_meta;
        @(posedge clk);
        #1;
        noc_in_data = req_flit;
        @(posedge clk);                                 // Request flit captured here
        #1;
        noc_in_val  = 1'b0;
        noc_in_data = '0;

        exp_wait = addr[log_addr_w] ? 0 : 2;
        wait_n   = 0;
        @(negedge clk);
        while (!noc_out_val && wait_n < 8) begin
            wait_n++;
            @(negedge clk);
        end
        check_val({name, " header valid"}, 1'b1, noc_out_val);
        check_latency({name, " reply latency"}, exp_wait, wait_n);

        exp_hdr                = '0;
        exp_hdr.dst_x          = udp_tx_x;
        exp_hdr.dst_y          = udp_tx_y;
        exp_hdr.src_x          = tile_x;
        exp_hdr.src_y          = tile_y;
        exp_hdr.msg_len        = 8'd2;
        exp_hdr.msg_type       = msg_udp_tx_segment;
        exp_hdr.metadata_flits = 8'd1;
        check_hdr({name, " header"}, exp_hdr, noc_out_data);

        @(negedge clk);
        check_val({name, " metadata valid"}, 1'b1, noc_out_val);
        exp_meta.src_ip      = req_meta.dst_ip;
        exp_meta.dst_ip      = req_meta.src_ip;
        exp_meta.src_port    = req_meta.dst_port;
        exp_meta.dst_port    = req_meta.src_port;
        exp_meta.data_length = 16'd8;
        check_meta({name, " metadata"}, exp_meta, noc_out_data);

        @(negedge clk);
        check_val({name, " response valid"}, 1'b1, noc_out_val);
        exp_resp                   = '0;
        exp_resp.rd_resp.resp_addr = log_client_addr_w'(addr);
        if (addr[log_addr_w]) begin
            exp_resp.rd_resp.resp_data = {16'(model_count), 16'h0000};
        end else begin
            exp_resp.rd_resp.resp_data = model_mem[addr[log_addr_w-1:0]];
        end
        check_resp({name, " response"}, exp_resp, noc_out_data);

        @(negedge clk);
        check_val({name, " reply end"}, 1'b0, noc_out_val);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        arst_n      = 1'b0;
        rec_val     = 1'b0;
        rec_event   = '0;
        noc_in_val  = 1'b0;
        noc_in_data = '0;
        model_count = 0;
        lcg_state   = 32'd91811;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (i = 0; i < num_events; i++) begin
            keep = (rand_below(3) == 0) && (i != num_events - 1);  // Some back to back
            record_event(rand_half(), keep);
            if (!keep) begin
                idle_cycles(rand_below(3));
            end
        end

        for (i = 0; i < num_events; i++) begin
            read_log("entry read", 7'(i));
            idle_cycles(rand_below(3));
        end

        read_log("partial count", {1'b1, log_addr_w'(rand_half())});

        for (i = 0; i < num_fill; i++) begin
            keep = (rand_below(2) == 0) && (i != num_fill - 1);
            record_event(rand_half(), keep);
        end

        for (i = num_events; i < log_depth; i++) begin
            read_log("filled entry read", 7'(i));
        end

        for (i = 0; i < num_meta_reads; i++) begin
            read_log("full count", {1'b1, log_addr_w'(rand_half())});
            idle_cycles(rand_below(3));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/logger_pkg.sv
logic/log_recorder.sv
logic/log_mem.sv
logic/log_read_ctrl.sv
logic/log_read_datap.sv
logic/logger_tile.sv
sim/logger_tile_tb.sv

/* Makefile */
TOP := logger_tile_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module logger_tile -f sim.f
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
